// ==== frontend.f ====
fe_pkg.sv
fetch_unit.sv
multi_channel_fifo.sv
inst_predecode.sv
frontend.sv
frontend_properties.sv
frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frontend testbench with Verilator

LOG=sim.log
FAIL_MSG="Testbench failed"

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module frontend_tb -f frontend.f -o frontend_sim
if [ $? -ne 0 ]; then
    echo "verilator build did not complete"
    exit 1
fi

./obj_dir/frontend_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi
exit 0

// ==== frontend_tb.sv ====
`default_nettype none

module frontend_tb;

    localparam int TOTAL_INSTS = 344;
    localparam int MAX_LAT = 4;
    // one lone word per request at the longest latency plus reset and slack
    localparam int CYCLE_LIMIT = TOTAL_INSTS * (MAX_LAT + 1) + 1000;
    localparam fe_pkg::addr_t ERR_LO = fe_pkg::RESET_PC + 32'h800;
    localparam fe_pkg::addr_t ERR_HI = fe_pkg::RESET_PC + 32'h840;

    logic clk;
    logic rst_n;
    logic redirect_i;
    fe_pkg::addr_t redirect_pc_i;
    logic imem_req_o;
    fe_pkg::addr_t imem_addr_o;
    logic imem_rvalid_i;
    fe_pkg::inst_word_t [1:0] imem_rdata_i;
    logic imem_err_i;
    fe_pkg::lane_cnt_t issue_num_i;
    logic backend_stall_i;
    fe_pkg::lane_mask_t inst_valid_o;
    fe_pkg::addr_t [1:0] inst_pc_o;
    fe_pkg::inst_word_t [1:0] inst_word_o;
    fe_pkg::reg_idx_t [1:0] inst_rs0_o;
    fe_pkg::reg_idx_t [1:0] inst_rs1_o;
    fe_pkg::reg_idx_t [1:0] inst_rd_o;
    fe_pkg::lane_mask_t inst_err_o;

    integer seed;
    fe_pkg::inst_word_t word_mem [1024];
    int lat_tab [1024];
    fe_pkg::addr_t exp_q [$];
    int check_cnt;
    int err_cnt;
    int test_err;
    int issued_cnt;
    int err_seen;
    int stall_left;
    int cycle_cnt;
    logic [6:0] class_seen;

    frontend u_frontend (.*);

    // upper address bits folded in below the class field
    function automatic fe_pkg::inst_word_t mem_word(input fe_pkg::addr_t addr);
        return word_mem[addr[11:2]] ^ {4'h0, addr[31:12], 8'h00};
    endfunction

    function automatic logic in_err_window(input fe_pkg::addr_t addr);
        return addr >= ERR_LO && addr < ERR_HI;
    endfunction

    // expected {rs0, rs1, rd}
    function automatic logic [14:0] ref_regs(input fe_pkg::inst_word_t w);
        case (w[31:28])
            fe_pkg::CLASS_REG_ALU: return {w[14:10], w[9:5], w[4:0]};
            fe_pkg::CLASS_IMM_ALU, fe_pkg::CLASS_LOAD: return {5'd0, w[9:5], w[4:0]};
            fe_pkg::CLASS_STORE, fe_pkg::CLASS_BRANCH: return {w[4:0], w[9:5], 5'd0};
            fe_pkg::CLASS_LINK: return {10'd0, fe_pkg::LINK_REG};
            default: return 15'd0;
        endcase
    endfunction

    task automatic check_pc(input fe_pkg::addr_t got, input fe_pkg::addr_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t: pc %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_word(input fe_pkg::inst_word_t got, input fe_pkg::inst_word_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t: word %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_reg(input fe_pkg::reg_idx_t got, input fe_pkg::reg_idx_t exp,
                             input string field);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t: %s is %0d, expected %0d", $time, field, got, exp);
        end
    endtask

    task automatic check_err(input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t: error flag %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_lane(input logic lane);
        fe_pkg::addr_t pc;
        fe_pkg::inst_word_t w;
        logic [14:0] regs;
        logic [2:0] cls;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("lane %0d issued an instruction beyond the expected stream", lane);
        end else begin
            pc = exp_q.pop_front();
            w = mem_word(pc);
            regs = ref_regs(w);
            check_pc(inst_pc_o[lane], pc);
            check_word(inst_word_o[lane], w);
            check_reg(inst_rs0_o[lane], regs[14:10], "rs0");
            check_reg(inst_rs1_o[lane], regs[9:5], "rs1");
            check_reg(inst_rd_o[lane], regs[4:0], "rd");
            check_err(inst_err_o[lane], in_err_window({pc[31:3], 3'b000}));
            // codes above 5 all count as the no-register class
            cls = (inst_word_o[lane][31:28] > 4'd5) ? 3'd6 : inst_word_o[lane][30:28];
            class_seen[cls] = 1'b1;
            if (inst_err_o[lane] === 1'b1) begin
                err_seen++;
            end
            issued_cnt++;
        end
    endtask

    task automatic expect_from(input fe_pkg::addr_t start);
        exp_q.delete();
        for (int i = 0; i < 256; i++) begin
            exp_q.push_back(start + fe_pkg::addr_t'(4 * i));
        end
    endtask

    // never pops more than the valid mask shows
    task automatic drive_backend(input logic random_mode);
        int avail;
        avail = int'(inst_valid_o[0]) + int'(inst_valid_o[1]);
        backend_stall_i = 1'b0;
        issue_num_i = fe_pkg::lane_cnt_t'(avail);
        if (random_mode) begin
            if (stall_left == 0 && {$random(seed)} % 8 == 0) begin
                stall_left = 1 + int'({$random(seed)} % 5);
            end
            if (stall_left > 0) begin
                backend_stall_i = 1'b1;
                stall_left--;
            end
            issue_num_i = fe_pkg::lane_cnt_t'({$random(seed)} % (avail + 1));
        end
    endtask

    task automatic issue_instructions(input int n, input logic random_mode);
        int start;
        start = issued_cnt;
        while (issued_cnt - start < n) begin
            @(posedge clk);
            #1;
            drive_backend(random_mode);
        end
        @(posedge clk);
        #1;
        issue_num_i = 2'd0;
        backend_stall_i = 1'b0;
    endtask

    task automatic redirect_to(input fe_pkg::addr_t target);
        @(posedge clk);
        #1;
        issue_num_i = 2'd0;
        backend_stall_i = 1'b0;
        redirect_i = 1'b1;
        redirect_pc_i = target;
        @(posedge clk);
        #1;
        redirect_i = 1'b0;
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %0d errors", num, name, err_cnt + test_err - errs_before);
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one in-order response per request
    initial begin : memory_model
        fe_pkg::addr_t req_addr;
        logic [9:0] req_idx;
        imem_rvalid_i = 1'b0;
        imem_rdata_i = '0;
        imem_err_i = 1'b0;
        req_idx = '0;
        forever begin
            @(negedge clk);
            if (imem_req_o === 1'b1) begin
                req_addr = imem_addr_o;
                repeat (lat_tab[req_idx]) @(posedge clk);
                #1;
                imem_rvalid_i = 1'b1;
                imem_rdata_i = {mem_word(req_addr + 32'd4), mem_word(req_addr)};
                imem_err_i = in_err_window(req_addr);
                @(posedge clk);
                #1;
                imem_rvalid_i = 1'b0;
                req_idx = req_idx + 10'd1;
            end
        end
    end

    initial begin : compare
        check_cnt = 0;
        err_cnt = 0;
        issued_cnt = 0;
        err_seen = 0;
        class_seen = '0;
        expect_from(fe_pkg::RESET_PC);
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (inst_valid_o == 2'b10) begin
                    err_cnt++;
                    $display("FAILED %0t: lane 1 valid without lane 0", $time);
                end
                if (redirect_i) begin
                    expect_from(redirect_pc_i);
                end else if (!backend_stall_i) begin
                    if (issue_num_i != 2'd0) begin
                        check_lane(1'b0);
                    end
                    if (issue_num_i == 2'd2) begin
                        check_lane(1'b1);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        int errs;
        int seen;
        rst_n = 1'b0;
        redirect_i = 1'b0;
        redirect_pc_i = '0;
        issue_num_i = '0;
        backend_stall_i = 1'b0;
        stall_left = 0;
        test_err = 0;
        seed = 32'hec11b864;
        for (int i = 0; i < 1024; i++) begin
            word_mem[10'(i)] = $random(seed);
            // even words step through class codes 0 to 6
            if (i % 2 == 0) begin
                word_mem[10'(i)][31:28] = 4'(i / 2 % 7);
            end
            lat_tab[10'(i)] = 1 + int'({$random(seed)} % MAX_LAT);
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (inst_valid_o !== 2'b00) begin
            test_err++;
            $display("decoded queue is not empty after reset");
        end

        errs = err_cnt + test_err;
        issue_instructions(40, 1'b0);
        end_test(1, "sequential fetch after reset", errs);

        errs = err_cnt + test_err;
        issue_instructions(80, 1'b0);
        if (class_seen != 7'h7f) begin
            test_err++;
            $display("not every instruction class was issued, seen mask %b", class_seen);
        end
        end_test(2, "register fields of all classes", errs);

        errs = err_cnt + test_err;
        redirect_to(fe_pkg::RESET_PC + 32'h204);
        issue_instructions(20, 1'b0);
        redirect_to(fe_pkg::RESET_PC + 32'h400);
        issue_instructions(20, 1'b0);
        end_test(3, "redirect", errs);

        errs = err_cnt + test_err;
        issue_instructions(120, 1'b1);
        end_test(4, "random issue and stalls", errs);

        errs = err_cnt + test_err;
        seen = err_seen;
        redirect_to(fe_pkg::RESET_PC + 32'h7e0);
        issue_instructions(64, 1'b0);
        if (err_seen == seen) begin
            test_err++;
            $display("no instruction from the error window was issued");
        end
        end_test(5, "error window", errs);

        $display("5 tests, %0d checks, %0d errors", check_cnt, err_cnt + test_err);
        if (err_cnt + test_err == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== frontend_properties.sv ====
`default_nettype none

module frontend_properties (
    input wire                      clk,
    input wire                      rst_n,
    input wire                      imem_req_o,
    input wire  fe_pkg::addr_t      imem_addr_o,
    input wire                      imem_rvalid_i,
    input wire  fe_pkg::lane_mask_t inst_valid_o
);

    // high from a request until its response
    logic pending_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (imem_req_o) begin
            pending_q <= 1'b1;
        end else if (imem_rvalid_i) begin
            pending_q <= 1'b0;
        end
    end

    no_req_in_reset: assert property (@(posedge clk) !rst_n |-> imem_req_o !== 1'b1)
        else $error("memory request while in reset");

    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_o |-> !pending_q)
        else $error("second memory request before the response");

    aligned_req: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_o |-> imem_addr_o[2:0] == 3'b000)
        else $error("memory request address not pair aligned");

    lane1_needs_lane0: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid_o[1] |-> inst_valid_o[0])
        else $error("lane 1 valid without lane 0");

endmodule

bind frontend frontend_properties u_properties (
    .clk           (clk),
    .rst_n         (rst_n),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_rvalid_i (imem_rvalid_i),
    .inst_valid_o  (inst_valid_o)
);

`default_nettype wire

// ==== frontend.sv ====
`default_nettype none

module frontend (
    input  wire                             clk,
    input  wire                             rst_n,

    // redirect from the back end
    input  wire                             redirect_i,
    input  wire  fe_pkg::addr_t             redirect_pc_i,

    // instruction memory port
    output logic                            imem_req_o,
    output fe_pkg::addr_t                   imem_addr_o,
    input  wire                             imem_rvalid_i,
    input  wire  fe_pkg::inst_word_t [1:0]  imem_rdata_i,
    input  wire                             imem_err_i,

    // issue side
    input  wire  fe_pkg::lane_cnt_t         issue_num_i,
    input  wire                             backend_stall_i,
    output fe_pkg::lane_mask_t              inst_valid_o,
    output fe_pkg::addr_t [1:0]             inst_pc_o,
    output fe_pkg::inst_word_t [1:0]        inst_word_o,
    output fe_pkg::reg_idx_t [1:0]          inst_rs0_o,
    output fe_pkg::reg_idx_t [1:0]          inst_rs1_o,
    output fe_pkg::reg_idx_t [1:0]          inst_rd_o,
    output fe_pkg::lane_mask_t              inst_err_o
);

    // fetch to raw queue
    fe_pkg::lane_cnt_t fetch_num;
    fe_pkg::addr_t [1:0] fetch_pc;
    fe_pkg::inst_word_t [1:0] fetch_word;
    logic fetch_err;
    logic raw_ready;
    logic [1:0][fe_pkg::RAW_WIDTH-1:0] raw_wr_data;

    // raw queue to predecode
    logic [1:0][fe_pkg::RAW_WIDTH-1:0] raw_rd_data;
    fe_pkg::lane_mask_t raw_valid;
    fe_pkg::inst_word_t [1:0] raw_word;
    fe_pkg::lane_cnt_t xfer_num;
    fe_pkg::reg_idx_t [1:0] dec_rs0;
    fe_pkg::reg_idx_t [1:0] dec_rs1;
    fe_pkg::reg_idx_t [1:0] dec_rd;

    // decoded queue
    logic dec_ready;
    logic [1:0][fe_pkg::DEC_WIDTH-1:0] dec_wr_data;
    logic [1:0][fe_pkg::DEC_WIDTH-1:0] dec_rd_data;
    fe_pkg::lane_cnt_t pop_num;

    for (genvar i = 0; i < 2; i++) begin : g_lane
        assign raw_wr_data[i] = {fetch_err, fetch_pc[i], fetch_word[i]};
        assign raw_word[i] = raw_rd_data[i][$bits(fe_pkg::inst_word_t)-1:0];
        assign dec_wr_data[i] = {raw_rd_data[i], dec_rs0[i], dec_rs1[i], dec_rd[i]};
        assign {inst_err_o[i], inst_pc_o[i], inst_word_o[i],
                inst_rs0_o[i], inst_rs1_o[i], inst_rd_o[i]} = dec_rd_data[i];
    end

    // nothing leaves while the back end stalls
    assign pop_num = backend_stall_i ? 2'd0 : issue_num_i;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .write_ready_i (raw_ready),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_rvalid_i (imem_rvalid_i),
        .imem_rdata_i  (imem_rdata_i),
        .imem_err_i    (imem_err_i),
        .write_num_o   (fetch_num),
        .write_pc_o    (fetch_pc),
        .write_word_o  (fetch_word),
        .write_err_o   (fetch_err)
    );

    multi_channel_fifo #(
        .DATA_WIDTH (fe_pkg::RAW_WIDTH),
        .DEPTH      (fe_pkg::RAW_DEPTH),
        .BANK       (fe_pkg::RAW_BANK)
    ) u_raw_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (redirect_i),
        .write_num_i   (fetch_num),
        .write_data_i  (raw_wr_data),
        .write_ready_o (raw_ready),
        .read_num_i    (xfer_num),
        .read_valid_o  (raw_valid),
        .read_data_o   (raw_rd_data)
    );

    inst_predecode u_predecode (
        .raw_valid_i (raw_valid),
        .word_i      (raw_word),
        .dec_ready_i (dec_ready),
        .xfer_num_o  (xfer_num),
        .rs0_o       (dec_rs0),
        .rs1_o       (dec_rs1),
        .rd_o        (dec_rd)
    );

    multi_channel_fifo #(
        .DATA_WIDTH (fe_pkg::DEC_WIDTH),
        .DEPTH      (fe_pkg::DEC_DEPTH),
        .BANK       (fe_pkg::DEC_BANK)
    ) u_dec_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (redirect_i),
        .write_num_i   (xfer_num),
        .write_data_i  (dec_wr_data),
        .write_ready_o (dec_ready),
        .read_num_i    (pop_num),
        .read_valid_o  (inst_valid_o),
        .read_data_o   (dec_rd_data)
    );

endmodule

`default_nettype wire

// ==== inst_predecode.sv ====
`default_nettype none

module inst_predecode (
    // head of the raw queue
    input  wire  fe_pkg::lane_mask_t        raw_valid_i,
    input  wire  fe_pkg::inst_word_t [1:0]  word_i,

    // decoded queue has room for two
    input  wire                             dec_ready_i,

    output fe_pkg::lane_cnt_t               xfer_num_o,
    output fe_pkg::reg_idx_t [1:0]          rs0_o,
    output fe_pkg::reg_idx_t [1:0]          rs1_o,
    output fe_pkg::reg_idx_t [1:0]          rd_o
);

    fe_pkg::lane_cnt_t raw_cnt;

    // mask to count, capped at two
    assign raw_cnt = {raw_valid_i[1], raw_valid_i[0] & ~raw_valid_i[1]};

    // all or nothing while the decoded queue is short of room
    assign xfer_num_o = dec_ready_i ? raw_cnt : 2'd0;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rs0_o[i] = '0;
            rs1_o[i] = '0;
            rd_o[i] = '0;

            case (word_i[i][31:28])
                fe_pkg::CLASS_REG_ALU: begin
                    rs0_o[i] = word_i[i][14:10];
                    rs1_o[i] = word_i[i][9:5];
                    rd_o[i] = word_i[i][4:0];
                end
                fe_pkg::CLASS_IMM_ALU, fe_pkg::CLASS_LOAD: begin
                    rs1_o[i] = word_i[i][9:5];
                    rd_o[i] = word_i[i][4:0];
                end
                // rd field is a source for these two
                fe_pkg::CLASS_STORE, fe_pkg::CLASS_BRANCH: begin
                    rs0_o[i] = word_i[i][4:0];
                    rs1_o[i] = word_i[i][9:5];
                end
                fe_pkg::CLASS_LINK: begin
                    rd_o[i] = fe_pkg::LINK_REG;
                end
                default: begin
                    // no register operands
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== multi_channel_fifo.sv ====
`default_nettype none

module multi_channel_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH = 16,
    parameter int BANK = 4
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         flush_i,

    // write side, entry 0 first
    input  wire  fe_pkg::lane_cnt_t     write_num_i,
    input  wire  [1:0][DATA_WIDTH-1:0]  write_data_i,
    output logic                        write_ready_o,

    // read side, entry 0 is the oldest
    input  wire  fe_pkg::lane_cnt_t     read_num_i,
    output fe_pkg::lane_mask_t          read_valid_o,
    output logic [1:0][DATA_WIDTH-1:0]  read_data_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam int BANK_W = $clog2(BANK);
    localparam int ROWS = DEPTH / BANK;
    localparam int ROW_W = $clog2(ROWS);

    // pointers carry one wrap bit
    logic [CNT_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count;

    // slot index of the two entries at tail and head
    logic [1:0][PTR_W-1:0] wr_idx;
    logic [1:0][PTR_W-1:0] rd_idx;
    logic [1:0][BANK_W-1:0] wr_bank;
    logic [1:0][ROW_W-1:0] wr_row;
    logic [1:0][BANK_W-1:0] rd_bank;
    logic [1:0][ROW_W-1:0] rd_row;
    logic [1:0] wr_en;

    logic [BANK-1:0][DATA_WIDTH-1:0] bank_rdata;
    logic [BANK-1:0][ROW_W-1:0] bank_rd_row;

    assign count = wr_ptr_q - rd_ptr_q;

    // room for a full pair
    assign write_ready_o = (count <= CNT_W'(DEPTH - 2));

    // occupancy mask
    assign read_valid_o = {count >= CNT_W'(2), count != '0};

    assign wr_idx[0] = wr_ptr_q[PTR_W-1:0];
    assign wr_idx[1] = wr_ptr_q[PTR_W-1:0] + PTR_W'(1);
    assign rd_idx[0] = rd_ptr_q[PTR_W-1:0];
    assign rd_idx[1] = rd_ptr_q[PTR_W-1:0] + PTR_W'(1);

    // low index bits pick the bank, so neighbours never share one
    for (genvar l = 0; l < 2; l++) begin : g_lane
        assign wr_bank[l] = wr_idx[l][BANK_W-1:0];
        assign wr_row[l] = wr_idx[l][PTR_W-1:BANK_W];
        assign rd_bank[l] = rd_idx[l][BANK_W-1:0];
        assign rd_row[l] = rd_idx[l][PTR_W-1:BANK_W];
    end

    // flush wins over a write in the same cycle
    assign wr_en = flush_i ? 2'b00 : {write_num_i == 2'd2, write_num_i != 2'd0};

    for (genvar b = 0; b < BANK; b++) begin : g_bank
        logic [DATA_WIDTH-1:0] mem [ROWS];

        always_ff @(posedge clk) begin
            if (wr_en[0] && wr_bank[0] == BANK_W'(b)) begin
                mem[wr_row[0]] <= write_data_i[0];
            end else if (wr_en[1] && wr_bank[1] == BANK_W'(b)) begin
                mem[wr_row[1]] <= write_data_i[1];
            end
        end

        // each bank serves at most one of the two head entries
        assign bank_rd_row[b] = (rd_bank[0] == BANK_W'(b)) ? rd_row[0] : rd_row[1];
        assign bank_rdata[b] = mem[bank_rd_row[b]];
    end

    assign read_data_o[0] = bank_rdata[rd_bank[0]];
    assign read_data_o[1] = bank_rdata[rd_bank[1]];

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + CNT_W'(write_num_i);
            rd_ptr_q <= rd_ptr_q + CNT_W'(read_num_i);
        end
    end

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none

module fetch_unit (
    input  wire                           clk,
    input  wire                           rst_n,

    // redirect from the back end
    input  wire                           redirect_i,
    input  wire  fe_pkg::addr_t           redirect_pc_i,

    // raw queue has room for a full pair
    input  wire                           write_ready_i,

    // instruction memory port
    output logic                          imem_req_o,
    output fe_pkg::addr_t                 imem_addr_o,
    input  wire                           imem_rvalid_i,
    input  wire  fe_pkg::inst_word_t [1:0] imem_rdata_i,
    input  wire                           imem_err_i,

    // compacted write into the raw queue
    output fe_pkg::lane_cnt_t             write_num_o,
    output fe_pkg::addr_t [1:0]           write_pc_o,
    output fe_pkg::inst_word_t [1:0]      write_word_o,
    output logic                          write_err_o
);

    fe_pkg::addr_t pc_q;
    fe_pkg::addr_t req_pc_q;
    fe_pkg::addr_t pair_base;
    fe_pkg::lane_mask_t lane_valid;
    logic run_q;
    logic outstanding_q;
    logic discard_q;
    logic issue;
    logic accept;

    // one request in flight, and only with room for two words
    assign issue = run_q & ~outstanding_q & write_ready_i & ~redirect_i;

    assign imem_req_o = issue;
    assign imem_addr_o = {pc_q[31:3], 3'b000};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            pc_q <= fe_pkg::RESET_PC;
            outstanding_q <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            // first request one cycle after reset is released
            run_q <= 1'b1;

            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (issue) begin
                pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
            end

            if (issue) begin
                outstanding_q <= 1'b1;
            end else if (imem_rvalid_i) begin
                outstanding_q <= 1'b0;
            end

            // response of a request older than the redirect is stale
            if (imem_rvalid_i) begin
                discard_q <= 1'b0;
            end else if (redirect_i && outstanding_q) begin
                discard_q <= 1'b1;
            end
        end
    end

    // pc of the pair in flight
    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc_q <= pc_q;
        end
    end

    assign pair_base = {req_pc_q[31:3], 3'b000};

    // lower word is skipped when entering at an odd word
    assign lane_valid = {1'b1, ~req_pc_q[2]};

    assign accept = imem_rvalid_i & outstanding_q & ~discard_q & ~redirect_i;

    always_comb begin
        write_num_o = 2'd0;
        if (accept) begin
            write_num_o = {lane_valid[1] & lane_valid[0], lane_valid[1] ^ lane_valid[0]};
        end

        write_pc_o[1] = pair_base | 32'd4;
        write_word_o[1] = imem_rdata_i[1];

        // a lone upper word moves down to entry 0
        if (lane_valid[0]) begin
            write_pc_o[0] = pair_base;
            write_word_o[0] = imem_rdata_i[0];
        end else begin
            write_pc_o[0] = pair_base | 32'd4;
            write_word_o[0] = imem_rdata_i[1];
        end
    end

    assign write_err_o = imem_err_i;

endmodule

`default_nettype wire

// ==== fe_pkg.sv ====
`default_nettype none

package fe_pkg;

    // address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_word_t;

    // architectural register number, 0 means no register
    typedef logic [4:0] reg_idx_t;

    // 0, 1 or 2 items per cycle
    typedef logic [1:0] lane_cnt_t;

    // one valid bit per lane
    typedef logic [1:0] lane_mask_t;

    // first fetch address after reset
    localparam addr_t RESET_PC = 32'h1c000000;

    // raw queue, holds fetched pairs
    localparam int RAW_DEPTH = 16;
    localparam int RAW_BANK = 4;

    // decoded queue in front of the back end
    localparam int DEC_DEPTH = 4;
    localparam int DEC_BANK = 2;

    // raw entry is {err, pc, word}
    localparam int RAW_WIDTH = 1 + $bits(addr_t) + $bits(inst_word_t);

    // decoded entry appends {rs0, rs1, rd}
    localparam int DEC_WIDTH = RAW_WIDTH + 3 * $bits(reg_idx_t);

    // instruction class, taken from inst[31:28]
    localparam logic [3:0] CLASS_REG_ALU = 4'd0;
    localparam logic [3:0] CLASS_IMM_ALU = 4'd1;
    localparam logic [3:0] CLASS_LOAD = 4'd2;
    localparam logic [3:0] CLASS_STORE = 4'd3;
    localparam logic [3:0] CLASS_BRANCH = 4'd4;
    // branch and link writes the link register only
    localparam logic [3:0] CLASS_LINK = 4'd5;
    // any other code carries no registers

    // return address register
    localparam reg_idx_t LINK_REG = 5'd1;

endpackage

`default_nettype wire
